// ==== include/sdp_rdma_eg_defs.svh ====
// width macros for the post-processing read DMA egress stage
// included by the package and by every module that sizes a bus from them
`ifndef SDP_RDMA_EG_DEFS_SVH
`define SDP_RDMA_EG_DEFS_SVH

// atoms carried by one DMA read response
`define EG_ATOMS_PER_BEAT 4
// bytes per atom
`define EG_ATOM_BYTES 8
// atom width in bits
`define EG_ATOM_W (`EG_ATOM_BYTES * 8)
// response payload width
`define EG_DATA_W (`EG_ATOMS_PER_BEAT * `EG_ATOM_W)
// atom index inside a beat
`define EG_IDX_W 2
// popcount of a beat mask, 0..4
`define EG_POP_W 3

// context entry atom count field, stored minus one
`define EG_SIZE_W 15
// running count must reach size plus one
`define EG_CNT_W (`EG_SIZE_W + 1)
// per-layer atom total of one stream
`define EG_LAYER_W 24

`endif

// ==== logic/eg_atom_serializer.sv ====
// one-group holding stage that emits its masked atoms one per cycle
// counts delivered atoms and flags the last atom of the layer
`timescale 1ns/1ps
`include "sdp_rdma_eg_defs.svh"

module eg_atom_serializer import sdp_rdma_eg_pkg::*; (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   op_load,
  input  logic [`EG_LAYER_W-1:0] layer_atoms,
  input  eg_group_t              group,
  input  logic                   grp_valid,
  output logic                   grp_ready,
  output eg_atom_t               out_atom,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic                   layer_end
);

  eg_atom_t [`EG_ATOMS_PER_BEAT-1:0] hold_atom;
  logic [`EG_ATOMS_PER_BEAT-1:0]     pend_mask;
  logic [`EG_ATOMS_PER_BEAT-1:0]     cur_bit;
  logic [`EG_IDX_W-1:0]              cur_idx;
  logic                              last_atom;
  logic                              grp_fire;
  logic                              out_fire;
  logic [`EG_LAYER_W-1:0]            atom_cnt;
  logic [`EG_LAYER_W-1:0]            atom_cnt_nxt;

  // ======================================================================
  // holding register
  // ======================================================================
  // lowest pending atom goes first
  assign cur_bit = pend_mask & (~pend_mask + 1'b1);

  always_comb begin
    cur_idx = '0;
    for (int i = `EG_ATOMS_PER_BEAT - 1; i >= 0; i--) begin
      if (pend_mask[i]) begin
        cur_idx = i[`EG_IDX_W-1:0];
      end
    end
  end

  assign last_atom = ((pend_mask & ~cur_bit) == '0);
  assign out_valid = |pend_mask;
  assign out_atom  = hold_atom[cur_idx];
  assign out_fire  = out_valid & out_ready;

  // refill while the final atom leaves, no bubble between groups
  assign grp_ready = !out_valid | (out_ready & last_atom);
  assign grp_fire  = grp_valid & grp_ready;

  always_ff @(posedge nvdla_core_clk) begin
    if (grp_fire) begin
      hold_atom <= group.atom;
    end
  end

  // pending bits drain one per transfer
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pend_mask <= '0;
    end else if (grp_fire) begin
      pend_mask <= group.mask;
    end else if (out_fire) begin
      pend_mask <= pend_mask & ~cur_bit;
    end
  end

  // ======================================================================
  // layer atom count
  // ======================================================================
  assign atom_cnt_nxt = atom_cnt + 1'b1;
  assign layer_end    = out_fire & (atom_cnt_nxt == layer_atoms);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      atom_cnt <= '0;
    end else if (op_load | layer_end) begin
      atom_cnt <= '0;
    end else if (out_fire) begin
      atom_cnt <= atom_cnt_nxt;
    end
  end

  // an empty group would leave the splitter and serializer out of step
  a_group_not_empty: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    grp_fire |-> (|group.mask))
    else $error("serializer accepted a group with an empty mask");

endmodule

// ==== logic/eg_beat_tracker.sv ====
// matches each DMA response against the head context entry
// pops the context queue on the entry's last beat and returns DMA credits
`timescale 1ns/1ps
`include "sdp_rdma_eg_defs.svh"

module eg_beat_tracker import sdp_rdma_eg_pkg::*; (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  eg_ctx_t                       ctx,
  input  logic                          ctx_valid,
  output logic                          ctx_ready,
  input  logic [`EG_ATOMS_PER_BEAT-1:0] rsp_mask,
  input  logic                          rsp_valid,
  input  logic                          rsp_fire,
  output logic                          cdt_pop
);

  logic [`EG_POP_W-1:0] beat_atoms;
  logic [`EG_CNT_W-1:0] beat_count;
  logic [`EG_CNT_W-1:0] beat_count_nxt;
  logic [`EG_CNT_W-1:0] beat_size;
  logic                 is_last_beat;

  // ======================================================================
  // atom accounting
  // ======================================================================
  // popcount of the response mask
  always_comb begin
    beat_atoms = '0;
    for (int i = 0; i < `EG_ATOMS_PER_BEAT; i++) begin
      beat_atoms = beat_atoms + {{(`EG_POP_W-1){1'b0}}, rsp_mask[i]};
    end
  end

  assign beat_size      = {1'b0, ctx.size} + 1'b1;
  assign beat_count_nxt = beat_count + {{(`EG_CNT_W-`EG_POP_W){1'b0}}, beat_atoms};
  assign is_last_beat   = (beat_count_nxt == beat_size);

  // running count, restarts at each entry boundary
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_count <= '0;
    end else if (rsp_fire) begin
      beat_count <= is_last_beat ? '0 : beat_count_nxt;
    end
  end

  // entry retires together with its final beat
  assign ctx_ready = rsp_fire & is_last_beat;
  // one credit back per accepted response
  assign cdt_pop   = rsp_fire;

  // context must already be queued when its data returns
  a_ctx_before_rsp: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    rsp_valid |-> ctx_valid)
    else $error("response valid without a context entry");

  // a beat may not carry atoms past the entry size
  a_no_overshoot: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    rsp_fire |-> (beat_count_nxt <= beat_size))
    else $error("beat atom count overshoots the context entry");

endmodule

// ==== logic/eg_lane_split.sv ====
// splits each response into an ALU group and a MUL group by operand use
// both mode interleaves even and odd elements, single mode passes the beat
`timescale 1ns/1ps
`include "sdp_rdma_eg_defs.svh"

module eg_lane_split import sdp_rdma_eg_pkg::*; (
  input  eg_cfg_t   cfg,
  input  eg_rsp_t   rsp,
  input  logic      rsp_valid,
  output logic      rsp_ready,
  output logic      rsp_fire,
  output eg_group_t alu_group,
  output logic      alu_grp_valid,
  input  logic      alu_grp_ready,
  output eg_group_t mul_group,
  output logic      mul_grp_valid,
  input  logic      mul_grp_ready
);

  eg_mode_t                      mode;
  logic                          lanes_ready;
  logic [`EG_ATOMS_PER_BEAT-1:0] both_mask;

  // gathers one atom of even or odd elements from one half of the beat
  // wide picks 16-bit elements, otherwise bytes
  function automatic eg_atom_t interleave(input logic [`EG_DATA_W-1:0] data,
                                          input int half, input int odd, input logic wide);
    eg_atom_t atom;
    int       base;
    atom = '0;
    base = half * (`EG_DATA_W / 2);
    if (wide) begin
      for (int i = 0; i < `EG_ATOM_W / 16; i++) begin
        atom[16*i +: 16] = data[base + 32*i + 16*odd +: 16];
      end
    end else begin
      for (int i = 0; i < `EG_ATOM_W / 8; i++) begin
        atom[8*i +: 8] = data[base + 16*i + 8*odd +: 8];
      end
    end
    return atom;
  endfunction

  assign mode      = eg_decode(cfg);
  // halves of a beat become atoms 0 and 1 of each lane
  assign both_mask = {2'b00, rsp.mask[2], rsp.mask[0]};

  // ======================================================================
  // payload slicing
  // ======================================================================
  always_comb begin
    alu_group.atom = rsp.data;
    mul_group.atom = rsp.data;
    alu_group.mask = mode.both ? both_mask : rsp.mask;
    mul_group.mask = mode.both ? both_mask : rsp.mask;
    if (mode.both) begin
      // even elements to alu, odd to mul
      alu_group.atom[0] = interleave(rsp.data, 0, 0, cfg.elem_size);
      alu_group.atom[1] = interleave(rsp.data, 1, 0, cfg.elem_size);
      mul_group.atom[0] = interleave(rsp.data, 0, 1, cfg.elem_size);
      mul_group.atom[1] = interleave(rsp.data, 1, 1, cfg.elem_size);
    end
  end

  // ======================================================================
  // handshake join
  // ======================================================================
  // disabled lanes never hold the response back
  assign lanes_ready = (!mode.alu_en | alu_grp_ready) & (!mode.mul_en | mul_grp_ready);
  assign rsp_ready   = rsp_valid & (mode.alu_en | mode.mul_en) & lanes_ready;
  assign rsp_fire    = rsp_valid & rsp_ready;

  // both mode loads the two lanes in the same cycle
  assign alu_grp_valid = rsp_valid & mode.alu_en & (!mode.both | lanes_ready);
  assign mul_grp_valid = rsp_valid & mode.mul_en & (!mode.both | lanes_ready);

endmodule

// ==== logic/eg_layer_done.sv ====
// collects layer completion of the alu and mul streams
// raises a one-cycle done once every enabled stream has finished
`timescale 1ns/1ps

module eg_layer_done import sdp_rdma_eg_pkg::*; (
  input  logic    nvdla_core_clk,
  input  logic    nvdla_core_rstn,
  input  logic    op_load,
  input  eg_cfg_t cfg,
  input  logic    alu_layer_end,
  input  logic    mul_layer_end,
  output logic    done
);

  eg_mode_t mode;
  logic     alu_fin;
  logic     mul_fin;
  logic     layer_done;

  assign mode       = eg_decode(cfg);
  assign layer_done = alu_fin & mul_fin;

  // disabled stream starts out finished
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      alu_fin <= 1'b0;
      mul_fin <= 1'b0;
    end else if (op_load) begin
      alu_fin <= !mode.alu_en;
      mul_fin <= !mode.mul_en;
    end else begin
      // end of a stream wins over the clear
      alu_fin <= alu_layer_end | (alu_fin & !layer_done);
      mul_fin <= mul_layer_end | (mul_fin & !layer_done);
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      done <= 1'b0;
    end else begin
      done <= layer_done;
    end
  end

endmodule

// ==== logic/sdp_rdma_eg.sv ====
// egress stage of the post-processing read DMA
// latency FIFO data in, alu and mul atom streams out, done per layer
`timescale 1ns/1ps

module sdp_rdma_eg import sdp_rdma_eg_pkg::*; (
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  logic      op_load,
  input  eg_cfg_t   cfg,
  input  eg_ctx_t   ctx,
  input  logic      ctx_valid,
  output logic      ctx_ready,
  input  eg_rsp_t   rsp,
  input  logic      rsp_valid,
  output logic      rsp_ready,
  output logic      cdt_pop,
  output eg_atom_t  alu_atom,
  output logic      alu_valid,
  input  logic      alu_ready,
  output eg_atom_t  mul_atom,
  output logic      mul_valid,
  input  logic      mul_ready,
  output logic      done
);

  logic      rsp_fire;
  eg_group_t alu_group;
  logic      alu_grp_valid;
  logic      alu_grp_ready;
  eg_group_t mul_group;
  logic      mul_grp_valid;
  logic      mul_grp_ready;
  logic      alu_layer_end;
  logic      mul_layer_end;

  // ======================================================================
  // context match and credit return
  // ======================================================================
  eg_beat_tracker u_tracker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .ctx             (ctx),
    .ctx_valid       (ctx_valid),
    .ctx_ready       (ctx_ready),
    .rsp_mask        (rsp.mask),
    .rsp_valid       (rsp_valid),
    .rsp_fire        (rsp_fire),
    .cdt_pop         (cdt_pop)
  );

  // lane slicing and ready join
  eg_lane_split u_split (
    .cfg           (cfg),
    .rsp           (rsp),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_fire      (rsp_fire),
    .alu_group     (alu_group),
    .alu_grp_valid (alu_grp_valid),
    .alu_grp_ready (alu_grp_ready),
    .mul_group     (mul_group),
    .mul_grp_valid (mul_grp_valid),
    .mul_grp_ready (mul_grp_ready)
  );

  // ======================================================================
  // per-stream serializers
  // ======================================================================
  eg_atom_serializer u_alu (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .layer_atoms     (cfg.layer_atoms),
    .group           (alu_group),
    .grp_valid       (alu_grp_valid),
    .grp_ready       (alu_grp_ready),
    .out_atom        (alu_atom),
    .out_valid       (alu_valid),
    .out_ready       (alu_ready),
    .layer_end       (alu_layer_end)
  );

  eg_atom_serializer u_mul (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .layer_atoms     (cfg.layer_atoms),
    .group           (mul_group),
    .grp_valid       (mul_grp_valid),
    .grp_ready       (mul_grp_ready),
    .out_atom        (mul_atom),
    .out_valid       (mul_valid),
    .out_ready       (mul_ready),
    .layer_end       (mul_layer_end)
  );

  // layer completion
  eg_layer_done u_done (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cfg             (cfg),
    .alu_layer_end   (alu_layer_end),
    .mul_layer_end   (mul_layer_end),
    .done            (done)
  );

endmodule

// ==== logic/sdp_rdma_eg_pkg.sv ====
// shared types of the egress stage plus the operand-use decode
// imported with a wildcard by every egress module
`include "sdp_rdma_eg_defs.svh"

package sdp_rdma_eg_pkg;

  // operand use, same encoding as the register field
  typedef enum logic [1:0] {
    EG_USE_MUL  = 2'd0,
    EG_USE_ALU  = 2'd1,
    EG_USE_BOTH = 2'd2
  } eg_use_e;

  typedef logic [`EG_ATOM_W-1:0] eg_atom_t;

  // register config, stable from op_load until done
  typedef struct packed {
    eg_use_e                 data_use;
    logic                    elem_size;   // 0 means 1 byte
    logic [`EG_LAYER_W-1:0]  layer_atoms;
  } eg_cfg_t;

  // context queue entry, atom count of the beat minus one
  typedef struct packed {
    logic [`EG_SIZE_W-1:0] size;
  } eg_ctx_t;

  // latency FIFO read word
  typedef struct packed {
    logic [`EG_ATOMS_PER_BEAT-1:0] mask;
    logic [`EG_DATA_W-1:0]         data;
  } eg_rsp_t;

  // one stream's share of a beat
  typedef struct packed {
    logic [`EG_ATOMS_PER_BEAT-1:0]     mask;
    eg_atom_t [`EG_ATOMS_PER_BEAT-1:0] atom;
  } eg_group_t;

  typedef struct packed {
    logic alu_en;
    logic mul_en;
    logic both;
  } eg_mode_t;

  // unknown use codes enable nothing
  function automatic eg_mode_t eg_decode(input eg_cfg_t cfg);
    eg_mode_t mode;
    mode.both   = (cfg.data_use == EG_USE_BOTH);
    mode.alu_en = (cfg.data_use == EG_USE_ALU) | mode.both;
    mode.mul_en = (cfg.data_use == EG_USE_MUL) | mode.both;
    return mode;
  endfunction

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the egress testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module sdp_rdma_eg_tb \
  -f sdp_rdma_eg.f -o sdp_rdma_eg_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sdp_rdma_eg_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; } \
  || grep -q "TESTS PASSED" sim.log || { echo "no result in log"; exit 1; }

// ==== sdp_rdma_eg.f ====
+incdir+include
logic/sdp_rdma_eg_pkg.sv
logic/eg_beat_tracker.sv
logic/eg_lane_split.sv
logic/eg_atom_serializer.sv
logic/eg_layer_done.sv
logic/sdp_rdma_eg.sv
tests/sdp_rdma_eg_tb.sv

// ==== tests/sdp_rdma_eg_tb.sv ====
// self-checking testbench for the read DMA egress stage
// table rows are driven as DMA beats and checked against a reference model
// output readies toggle randomly and a watchdog bounds the run
`timescale 1ns/1ps
`include "sdp_rdma_eg_defs.svh"

module sdp_rdma_eg_tb import sdp_rdma_eg_pkg::*; ();

  // one layer per row with masks packed per beat and context sizes per entry
  typedef struct packed {
    eg_use_e                data_use;
    logic                   elem_size;
    logic [`EG_LAYER_W-1:0] layer_atoms;
    logic [3:0]             n_beats;
    logic [31:0]            masks;     // beat b in nibble b
    logic [2:0]             n_ctx;
    logic [31:0]            ctx_size;  // entry e in byte e as size minus one
  } row_t;

  localparam int NROWS = 5;

  logic     nvdla_core_clk;
  logic     nvdla_core_rstn;
  logic     op_load;
  eg_cfg_t  cfg;
  eg_ctx_t  ctx;
  logic     ctx_valid;
  logic     ctx_ready;
  eg_rsp_t  rsp;
  logic     rsp_valid;
  logic     rsp_ready;
  logic     cdt_pop;
  eg_atom_t alu_atom;
  logic     alu_valid;
  logic     alu_ready;
  eg_atom_t mul_atom;
  logic     mul_valid;
  logic     mul_ready;
  logic     done;

  integer                 seed = 13408;
  row_t                   rows [NROWS];
  logic [`EG_DATA_W-1:0]  beat_data [8];
  eg_atom_t               exp_alu [$];
  eg_atom_t               exp_mul [$];
  // owned by the output monitor
  int                     alu_idx;
  int                     mul_idx;
  int                     done_count;
  int                     done_wait;
  int                     cdt_count;
  int                     ctx_count;

  sdp_rdma_eg UUT (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cfg             (cfg),
    .ctx             (ctx),
    .ctx_valid       (ctx_valid),
    .ctx_ready       (ctx_ready),
    .rsp             (rsp),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .cdt_pop         (cdt_pop),
    .alu_atom        (alu_atom),
    .alu_valid       (alu_valid),
    .alu_ready       (alu_ready),
    .mul_atom        (mul_atom),
    .mul_valid       (mul_valid),
    .mul_ready       (mul_ready),
    .done            (done)
  );

  initial nvdla_core_clk = 1'b0;
  always #10 nvdla_core_clk = ~nvdla_core_clk;

  // ======================================================================
  // error reporting and compare tasks
  // ======================================================================
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_atom(input string port, input eg_atom_t got, input eg_atom_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL time %0t: %s atom got %h expected %h", $time, port, got, exp));
    end
  endtask

  task automatic check_done(input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL time %0t: done got %b expected %b", $time, got, exp));
    end
  endtask

  task automatic check_handshake(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL time %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      stop_run($sformatf("FAIL time %0t: %s got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  // ======================================================================
  // reference model
  // ======================================================================
  function automatic int mask_atoms(input logic [3:0] m);
    int n;
    n = 0;
    for (int i = 0; i < 4; i++) begin
      n += int'(m[i]);
    end
    return n;
  endfunction

  // even or odd elements of one 128-bit half built byte by byte
  function automatic eg_atom_t half_elems(input logic [`EG_DATA_W-1:0] data, input int half,
                                          input int odd, input logic wide);
    eg_atom_t atom;
    int       src;
    for (int b = 0; b < 8; b++) begin
      if (wide) begin
        src = 2 * (8 * half + 2 * (b / 2) + odd) + b % 2;
      end else begin
        src = 16 * half + 2 * b + odd;
      end
      atom[8*b +: 8] = data[8*src +: 8];
    end
    return atom;
  endfunction

  task automatic build_expect(input row_t r);
    logic [3:0] m;
    exp_alu.delete();
    exp_mul.delete();
    for (int b = 0; b < int'(r.n_beats); b++) begin
      m = r.masks[4*b +: 4];
      for (int w = 0; w < 8; w++) begin
        beat_data[b][32*w +: 32] = $random(seed);
      end
      if (r.data_use == EG_USE_BOTH) begin
        // mask bits 0 and 2 gate the low and high half
        for (int h = 0; h < 2; h++) begin
          if (m[2*h]) begin
            exp_alu.push_back(half_elems(beat_data[b], h, 0, r.elem_size));
            exp_mul.push_back(half_elems(beat_data[b], h, 1, r.elem_size));
          end
        end
      end else begin
        for (int k = 0; k < 4; k++) begin
          if (m[k] && r.data_use == EG_USE_ALU) begin
            exp_alu.push_back(beat_data[b][64*k +: 64]);
          end else if (m[k]) begin
            exp_mul.push_back(beat_data[b][64*k +: 64]);
          end
        end
      end
    end
  endtask

  function automatic int total_atoms();
    int n;
    n = 0;
    for (int r = 0; r < NROWS; r++) begin
      for (int b = 0; b < int'(rows[r].n_beats); b++) begin
        n += mask_atoms(rows[r].masks[4*b +: 4]);
      end
    end
    return n;
  endfunction

  // use, elem size, layer atoms, beats, masks, entries, entry sizes
  task automatic load_rows();
    rows[0] = '{EG_USE_MUL,  1'b0, 24'd12, 4'd3, 32'h0000_0FFF, 3'd2, 32'h0000_0307};
    rows[1] = '{EG_USE_ALU,  1'b0, 24'd9,  4'd4, 32'h0000_1C3F, 3'd2, 32'h0000_0205};
    rows[2] = '{EG_USE_BOTH, 1'b0, 24'd8,  4'd5, 32'h000F_415F, 3'd3, 32'h0003_0105};
    rows[3] = '{EG_USE_BOTH, 1'b1, 24'd7,  4'd4, 32'h0000_E5FF, 3'd2, 32'h0000_0803};
    rows[4] = '{EG_USE_MUL,  1'b0, 24'd5,  4'd3, 32'h0000_0A68, 3'd2, 32'h0000_0300};
  endtask

  // ======================================================================
  // stimulus
  // ======================================================================
  task automatic drive_beat(input row_t r, input int beat, input int entry);
    rsp       <= '{mask: r.masks[4*beat +: 4], data: beat_data[beat]};
    rsp_valid <= 1'b1;
    ctx       <= '{size: {7'd0, r.ctx_size[8*entry +: 8]}};
    ctx_valid <= 1'b1;
  endtask

  task automatic run_row(input row_t r);
    int         entry;
    int         run_cnt;
    int         beat;
    logic [3:0] m;
    logic       last;
    build_expect(r);
    @(posedge nvdla_core_clk);
    cfg     <= '{data_use: r.data_use, elem_size: r.elem_size, layer_atoms: r.layer_atoms};
    op_load <= 1'b1;
    @(posedge nvdla_core_clk);
    op_load <= 1'b0;
    entry   = 0;
    run_cnt = 0;
    beat    = 0;
    drive_beat(r, 0, 0);
    while (beat < int'(r.n_beats)) begin
      @(posedge nvdla_core_clk);
      if (rsp_valid && rsp_ready) begin
        m    = r.masks[4*beat +: 4];
        // entry retires once its atoms add up to size plus one
        last = (run_cnt + mask_atoms(m) == int'(r.ctx_size[8*entry +: 8]) + 1);
        check_handshake("ctx_ready", ctx_ready, last);
        // every accepted beat returns one credit
        check_handshake("cdt_pop", cdt_pop, 1'b1);
        run_cnt = last ? 0 : run_cnt + mask_atoms(m);
        entry   = last ? entry + 1 : entry;
        beat++;
        if (beat < int'(r.n_beats)) begin
          drive_beat(r, beat, entry);
        end else begin
          rsp_valid <= 1'b0;
          ctx_valid <= 1'b0;
        end
      end
    end
    while (done_count == 0) begin
      @(posedge nvdla_core_clk);
    end
    // idle a few cycles to catch a second done
    repeat (4) @(posedge nvdla_core_clk);
    check_count("done pulses", done_count, 1);
    check_count("alu atoms", alu_idx, exp_alu.size());
    check_count("mul atoms", mul_idx, exp_mul.size());
    check_count("credit pops", cdt_count, int'(r.n_beats));
    check_count("context pops", ctx_count, int'(r.n_ctx));
  endtask

  // random back-pressure on both output streams
  initial begin
    alu_ready = 1'b0;
    mul_ready = 1'b0;
    forever begin
      @(posedge nvdla_core_clk);
      alu_ready <= ($random(seed) & 3) != 0;
      mul_ready <= ($random(seed) & 3) != 0;
    end
  end

  // ======================================================================
  // output monitor
  // ======================================================================
  always @(posedge nvdla_core_clk) begin : out_monitor
    logic alu_on;
    logic mul_on;
    logic moved;
    logic exp_done;
    if (!nvdla_core_rstn || op_load) begin
      alu_idx    = 0;
      mul_idx    = 0;
      done_count = 0;
      done_wait  = 0;
      cdt_count  = 0;
      ctx_count  = 0;
    end else begin
      alu_on   = (cfg.data_use == EG_USE_ALU) || (cfg.data_use == EG_USE_BOTH);
      mul_on   = (cfg.data_use == EG_USE_MUL) || (cfg.data_use == EG_USE_BOTH);
      // done lands two edges after the final atom transfer
      exp_done = (done_wait == 1);
      if (done_wait > 0) begin
        done_wait--;
      end
      check_done(done, exp_done);
      done_count += int'(done);
      cdt_count += int'(cdt_pop);
      ctx_count += int'(ctx_ready);
      moved = 1'b0;
      if ((alu_valid && !alu_on) || (mul_valid && !mul_on)) begin
        stop_run("a disabled output stream raised its valid");
      end
      if (alu_valid && alu_ready) begin
        if (alu_idx >= exp_alu.size()) begin
          stop_run("alu stream delivered more atoms than expected");
        end
        check_atom("alu", alu_atom, exp_alu[alu_idx]);
        alu_idx++;
        moved = 1'b1;
      end
      if (mul_valid && mul_ready) begin
        if (mul_idx >= exp_mul.size()) begin
          stop_run("mul stream delivered more atoms than expected");
        end
        check_atom("mul", mul_atom, exp_mul[mul_idx]);
        mul_idx++;
        moved = 1'b1;
      end
      if (moved && alu_idx == exp_alu.size() && mul_idx == exp_mul.size()) begin
        done_wait = 2;
      end
    end
  end

  // ======================================================================
  // main sequence and watchdog
  // ======================================================================
  initial begin
    nvdla_core_rstn = 1'b0;
    op_load         = 1'b0;
    cfg             = '0;
    ctx             = '0;
    ctx_valid       = 1'b0;
    rsp             = '0;
    rsp_valid       = 1'b0;
    load_rows();
    repeat (5) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    repeat (2) @(posedge nvdla_core_clk);
    for (int r = 0; r < NROWS; r++) begin
      run_row(rows[r]);
    end
    $display("TESTS PASSED");
    $finish;
  end

  // twenty cycles per atom plus setup margin
  initial begin
    longint limit_ns;
    #1;
    limit_ns = (longint'(total_atoms()) * 20 + 200) * 20;
    #(limit_ns);
    stop_run("watchdog timeout, the DUT stopped making progress");
  end

endmodule
